//--- huntScene.f
rtl/huntScenePkg.sv
rtl/dogSequencer.sv
rtl/duckFlight.sv
rtl/sceneCompositor.sv
rtl/huntScene.sv
verif/huntSceneTb.sv

//--- Makefile
# Verilator simulation of the hunt scene

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module huntSceneTb -f huntScene.f
	@out="$$(./obj_dir/VhuntSceneTb)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- verif/huntSceneTb.sv
`default_nettype none

module huntSceneTb
    import huntScenePkg::*;
();

    localparam int Period        = 8;
    localparam int TimeoutCycles = 200;
    localparam int IdleCycles    = 10;
    localparam int NumRows       = 8;
    localparam int SniffX        = 203;  // Last walk X plus one stride
    localparam int FirstDuck     = 57;   // Cycles counted from the Run edge
    localparam int DoneCycle     = 80;
    localparam int IdleAgain     = 81;

    // Run, colour, direction, start X, then launch frame and X, Y on the last duck tick
    localparam bit         rowRun    [NumRows] = '{0, 1, 1, 1, 1, 0, 1, 1};
    localparam logic [1:0] rowColor  [NumRows] = '{0, 0, 1, 2, 3, 1, 2, 1};
    localparam logic [1:0] rowDir    [NumRows] = '{0, 0, 1, 2, 3, 2, 1, 3};
    localparam logic [9:0] rowStartX [NumRows] = '{0, 500, 600, 100, 1020, 77, 3, 1023};
    localparam logic [5:0] rowFrame  [NumRows] = '{0, 11, 35, 40, 4, 0, 55, 24};
    localparam logic [9:0] rowEndX   [NumRows] = '{0, 408, 462, 192, 134, 0, 889, 137};
    localparam logic [9:0] rowEndY   [NumRows] = '{0, 208, 254, 208, 254, 0, 254, 254};

    logic       ANIM_Clk;
    logic       Reset;
    logic       Run;
    logic [1:0] duckColorRand;
    logic [1:0] duckDirRand;
    logic [9:0] duckStartXRand;
    logic [9:0] dogXOut;
    logic [9:0] dogYOut;
    logic [4:0] dogFrameOut;
    logic       dogVisible;
    logic [9:0] duckXOut;
    logic [9:0] duckYOut;
    logic [5:0] duckFrameOut;
    logic       duckVisible;
    logic       huntBusy;
    logic       huntDone;
    logic [9:0] statusLeds;
    int         checkCount;
    int         errorCount;
    bit         timedOut;
    bit         duckResting;  // A flight has ended and the duck holds still
    int         restX;
    int         restY;
    int         restFrame;

    huntScene dut (.*);

    initial
    begin
        ANIM_Clk = 1'b0;
        forever
            #(Period / 2) ANIM_Clk = ~ANIM_Clk;
    end

    task automatic nextTick();
        @(posedge ANIM_Clk);
        #1;  // Outputs settled, inputs change here
    endtask

    task automatic expectEqual(input string what, input int got, input int want);
        checkCount++;
        assert (got == want)
        else
        begin
            errorCount++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic dogExpected(input int c, output int x, output int y, output int frame,
                               output int phase);
        int i;
        x     = int'(DogHomeX);
        y     = int'(GroundY);
        frame = 0;
        phase = 0;
        if (c <= 20)
        begin
            i     = c - 1;  // Four frames per stride
            x     = int'(DogHomeX) + int'(StepDx) * (i % 4 + 1) + int'(StrideDx) * (i / 4);
            frame = i % 4 + 1;
            phase = 1;
        end
        else if (c <= 26)
        begin
            x     = SniffX;
            frame = 4 + (c - 21) % 2;
            phase = 2;
        end
        else if (c <= 28)
        begin
            x     = SniffX;
            frame = 6;
            phase = 3;
        end
        else if (c <= 48)
        begin
            i     = c - 29;
            x     = int'(JumpX[i]);
            y     = int'(JumpY[i]);
            frame = (i < JumpSteps) ? 7 : 8;
            phase = 4;
        end
        else if (c < IdleAgain)
        begin
            x     = int'(JumpX[19]);  // Landed behind the grass
            y     = int'(JumpY[19]);
            phase = (c <= 55) ? 5 : 6;
        end
    endtask

    task automatic duckExpected(input int c, input int row, output bit active, output int x,
                                output int y, output int frame);
        int t;
        int color;
        int dir;
        t      = c - FirstDuck;
        dir    = int'(rowDir[row]);
        color  = (rowColor[row] == 2'd3) ? 0 : int'(rowColor[row]);  // Colour 3 is black
        active = (t >= 0) && (t < FlightTicks);
        x      = (int'(rowStartX[row]) + t * int'(DuckDx[dir])) & 1023;
        y      = int'(DuckStartY) + t * int'(DuckDy[dir]);
        frame  = int'(DuckColorBase[color]) + int'(DuckDirBase[dir]) + t % DuckWingPhases;
    endtask

    task automatic checkIdle(input bit dogShown);
        expectEqual("dogXOut", int'(dogXOut), int'(DogHomeX));
        expectEqual("dogYOut", int'(dogYOut), int'(GroundY));
        expectEqual("dogFrameOut", int'(dogFrameOut), 0);
        expectEqual("huntBusy", int'(huntBusy), 0);
        expectEqual("huntDone", int'(huntDone), 0);
        expectEqual("duckVisible", int'(duckVisible), 0);
        expectEqual("statusLeds[3:0]", int'(statusLeds[3:0]), 0);
        expectEqual("dogVisible", int'(dogVisible), int'(dogShown));
    endtask

    task automatic checkDuckResting();
        expectEqual("duckXOut", int'(duckXOut), restX);
        expectEqual("duckYOut", int'(duckYOut), restY);
        expectEqual("duckFrameOut", int'(duckFrameOut), restFrame);
        expectEqual("statusLeds frame", int'(statusLeds[9:4]), restFrame);
    endtask

    task automatic holdIdle(input int row);
        duckColorRand  = rowColor[row];  // Must be ignored outside a launch
        duckDirRand    = rowDir[row];
        duckStartXRand = rowStartX[row];
        for (int n = 0; n < IdleCycles; n++)
        begin
            nextTick();
            checkIdle(1'b1);
            if (duckResting)
                checkDuckResting();
        end
    endtask

    task automatic runHunt(input int row);
        int c;
        int doneCount;
        int dX, dY, dFrame, dPhase;
        int uX, uY, uFrame;
        bit active;
        Run            = 1'b1;
        duckColorRand  = rowColor[row];
        duckDirRand    = rowDir[row];
        duckStartXRand = rowStartX[row];
        nextTick();  // Run seen in Idle
        Run       = 1'b0;
        c         = 0;
        doneCount = 0;
        while (c == 0 || huntBusy)
        begin
            if (c == TimeoutCycles)
            begin
                $display("Timeout: hunt of row %0d still busy after %0d cycles", row, c);
                timedOut = 1'b1;
                return;
            end
            nextTick();
            c++;
            dogExpected(c, dX, dY, dFrame, dPhase);
            duckExpected(c, row, active, uX, uY, uFrame);
            expectEqual("dogXOut", int'(dogXOut), dX);
            expectEqual("dogYOut", int'(dogYOut), dY);
            expectEqual("dogFrameOut", int'(dogFrameOut), dFrame);
            expectEqual("statusLeds phase", int'(statusLeds[2:0]), dPhase);
            expectEqual("huntBusy", int'(huntBusy), int'(dPhase != 0));
            expectEqual("dogVisible", int'(dogVisible),
                        int'((dPhase != 6) && (dY <= GrassY || dY == GroundY)));
            expectEqual("duckVisible", int'(duckVisible), int'(active && uY <= GrassY));
            expectEqual("statusLeds[3]", int'(statusLeds[3]), int'(active));
            expectEqual("huntDone", int'(huntDone), int'(c == DoneCycle));
            if (huntDone)
                doneCount++;
            if (active)
            begin
                expectEqual("duckXOut", int'(duckXOut), uX);
                expectEqual("duckYOut", int'(duckYOut), uY);
                expectEqual("duckFrameOut", int'(duckFrameOut), uFrame);
                expectEqual("statusLeds frame", int'(statusLeds[9:4]), uFrame);
            end
            else if (duckResting)
                checkDuckResting();
            if (c == FirstDuck)
            begin
                expectEqual("launch frame", int'(duckFrameOut), int'(rowFrame[row]));
                expectEqual("launch X", int'(duckXOut), int'(rowStartX[row]));
                expectEqual("launch Y", int'(duckYOut), int'(DuckStartY));
            end
            if (c == DoneCycle)
            begin
                expectEqual("final duck X", int'(duckXOut), int'(rowEndX[row]));
                expectEqual("final duck Y", int'(duckYOut), int'(rowEndY[row]));
                restX       = uX;  // Duck stays where its flight ended
                restY       = uY;
                restFrame   = uFrame;
                duckResting = 1'b1;
            end
        end
        expectEqual("hunt length", c, IdleAgain);
        expectEqual("huntDone pulses", doneCount, 1);
    endtask

    task automatic finishRun();
        $display("Checks run: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount,
                 timedOut);
        if (errorCount == 0 && !timedOut)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    initial
    begin
        Reset          = 1'b1;
        Run            = 1'b0;
        duckColorRand  = 2'd0;
        duckDirRand    = 2'd0;
        duckStartXRand = 10'd0;
        checkCount     = 0;
        errorCount     = 0;
        timedOut       = 1'b0;
        duckResting    = 1'b0;
        restX          = 0;
        restY          = 0;
        restFrame      = 0;
        repeat (3) @(posedge ANIM_Clk);
        #1;
        Reset = 1'b0;
        checkIdle(1'b0);  // Visibility register still holds its reset value
        for (int row = 0; row < NumRows && !timedOut; row++)
        begin
            if (rowRun[row])
                runHunt(row);
            else
                holdIdle(row);
        end
        finishRun();
    end

endmodule

`default_nettype wire

//--- rtl/huntScene.sv
`default_nettype none

module huntScene
(
    input  wire        ANIM_Clk,
    input  wire        Reset,
    input  wire        Run,
    input  wire  [1:0] duckColorRand,
    input  wire  [1:0] duckDirRand,
    input  wire  [9:0] duckStartXRand,
    output logic [9:0] dogXOut,
    output logic [9:0] dogYOut,
    output logic [4:0] dogFrameOut,
    output logic       dogVisible,
    output logic [9:0] duckXOut,
    output logic [9:0] duckYOut,
    output logic [5:0] duckFrameOut,
    output logic       duckVisible,
    output logic       huntBusy,
    output logic       huntDone,
    output logic [9:0] statusLeds
);

    logic [9:0] dogX;
    logic [9:0] dogY;
    logic [4:0] dogFrame;
    logic [2:0] dogPhase;
    logic       duckLaunch;   // Dog hands over to the duck
    logic       flightDone;   // Duck hands back to the dog
    logic [9:0] duckX;
    logic [9:0] duckY;
    logic [5:0] duckFrame;
    logic       duckActive;

    dogSequencer dogSeq
    (
        .ANIM_Clk   (ANIM_Clk),
        .Reset      (Reset),
        .Run        (Run),
        .flightDone (flightDone),
        .dogX       (dogX),
        .dogY       (dogY),
        .dogFrame   (dogFrame),
        .dogPhase   (dogPhase),
        .duckLaunch (duckLaunch)
    );

    duckFlight duck
    (
        .ANIM_Clk       (ANIM_Clk),
        .Reset          (Reset),
        .duckLaunch     (duckLaunch),
        .duckColorRand  (duckColorRand),
        .duckDirRand    (duckDirRand),
        .duckStartXRand (duckStartXRand),
        .duckX          (duckX),
        .duckY          (duckY),
        .duckFrame      (duckFrame),
        .duckActive     (duckActive),
        .flightDone     (flightDone)
    );

    sceneCompositor compositor
    (
        .ANIM_Clk     (ANIM_Clk),
        .Reset        (Reset),
        .dogX         (dogX),
        .dogY         (dogY),
        .dogFrame     (dogFrame),
        .dogPhase     (dogPhase),
        .duckX        (duckX),
        .duckY        (duckY),
        .duckFrame    (duckFrame),
        .duckActive   (duckActive),
        .flightDone   (flightDone),
        .dogXOut      (dogXOut),
        .dogYOut      (dogYOut),
        .dogFrameOut  (dogFrameOut),
        .dogVisible   (dogVisible),
        .duckXOut     (duckXOut),
        .duckYOut     (duckYOut),
        .duckFrameOut (duckFrameOut),
        .duckVisible  (duckVisible),
        .huntBusy     (huntBusy),
        .huntDone     (huntDone),
        .statusLeds   (statusLeds)
    );

endmodule

`default_nettype wire

//--- rtl/sceneCompositor.sv
`default_nettype none

module sceneCompositor
    import huntScenePkg::*;
(
    input  wire        ANIM_Clk,
    input  wire        Reset,
    input  wire  [9:0] dogX,
    input  wire  [9:0] dogY,
    input  wire  [4:0] dogFrame,
    input  wire  [2:0] dogPhase,
    input  wire  [9:0] duckX,
    input  wire  [9:0] duckY,
    input  wire  [5:0] duckFrame,
    input  wire        duckActive,
    input  wire        flightDone,
    output logic [9:0] dogXOut,
    output logic [9:0] dogYOut,
    output logic [4:0] dogFrameOut,
    output logic       dogVisible,
    output logic [9:0] duckXOut,
    output logic [9:0] duckYOut,
    output logic [5:0] duckFrameOut,
    output logic       duckVisible,
    output logic       huntBusy,
    output logic       huntDone,
    output logic [9:0] statusLeds
);

    logic dogShown;
    logic duckShown;

    // Standing row is drawn in front of the grass
    assign dogShown  = (dogPhase != DogPhaseHidden) && ((dogY <= GrassY) || (dogY == GroundY));
    assign duckShown = duckActive && (duckY <= GrassY);

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            dogXOut      <= DogHomeX;
            dogYOut      <= GroundY;
            dogFrameOut  <= DogFrameIdle;
            dogVisible   <= 1'b0;
            duckXOut     <= '0;
            duckYOut     <= DuckStartY;
            duckFrameOut <= '0;
            duckVisible  <= 1'b0;
            huntBusy     <= 1'b0;
            huntDone     <= 1'b0;
            statusLeds   <= '0;
        end
        else
        begin
            dogXOut      <= dogX;
            dogYOut      <= dogY;
            dogFrameOut  <= dogFrame;
            dogVisible   <= dogShown;
            duckXOut     <= duckX;
            duckYOut     <= duckY;
            duckFrameOut <= duckFrame;
            duckVisible  <= duckShown;
            huntBusy     <= (dogPhase != DogPhaseIdle);
            huntDone     <= flightDone;
            statusLeds   <= {duckFrame, duckActive, dogPhase};  // Frame, flying, phase
        end
    end

endmodule

`default_nettype wire

//--- rtl/duckFlight.sv
`default_nettype none

module duckFlight
    import huntScenePkg::*;
(
    input  wire        ANIM_Clk,
    input  wire        Reset,
    input  wire        duckLaunch,
    input  wire  [1:0] duckColorRand,
    input  wire  [1:0] duckDirRand,
    input  wire  [9:0] duckStartXRand,
    output logic [9:0] duckX,
    output logic [9:0] duckY,
    output logic [5:0] duckFrame,
    output logic       duckActive,
    output logic       flightDone
);

    logic [1:0] colorReg;
    logic [1:0] dirReg;    // 0 NW, 1 W, 2 NE, 3 E
    logic [4:0] tickCnt;   // Ticks since launch
    logic [1:0] wingCnt;   // Tick count modulo wing phases
    logic       lastTick;
    logic [9:0] stepX;
    logic [9:0] stepY;

    assign lastTick = (tickCnt == 5'(FlightTicks - 1));

    // Sign extend the per-direction step
    assign stepX = {{2{DuckDx[dirReg][7]}}, DuckDx[dirReg]};
    assign stepY = {{2{DuckDy[dirReg][7]}}, DuckDy[dirReg]};

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            duckActive <= 1'b0;
            tickCnt    <= '0;
            wingCnt    <= '0;
            colorReg   <= '0;
            dirReg     <= '0;
            duckX      <= '0;
            duckY      <= DuckStartY;
        end
        else if (duckLaunch)
        begin
            duckActive <= 1'b1;
            tickCnt    <= '0;
            wingCnt    <= '0;
            colorReg   <= (duckColorRand == 2'd3) ? 2'd0 : duckColorRand;  // 3 flies as black
            dirReg     <= duckDirRand;
            duckX      <= duckStartXRand;
            duckY      <= DuckStartY;
        end
        else if (duckActive)
        begin
            if (lastTick)
            begin
                duckActive <= 1'b0;
                tickCnt    <= '0;
            end
            else
            begin
                tickCnt <= tickCnt + 5'd1;
                if (wingCnt == 2'(DuckWingPhases - 1))
                    wingCnt <= '0;
                else
                    wingCnt <= wingCnt + 2'd1;
                duckX <= duckX + stepX;  // Wraps modulo 1024
                duckY <= duckY + stepY;
            end
        end
    end

    assign flightDone = duckActive && lastTick;

    assign duckFrame = DuckColorBase[colorReg] + DuckDirBase[dirReg] + {4'd0, wingCnt};

    tickInRange: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        tickCnt <= 5'(FlightTicks))
        else $error("Duck tick counter ran past the flight length");

    // Done comes from a flying duck, which lands on the next tick
    doneEndsFlight: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        flightDone |-> duckActive ##1 !duckActive)
        else $error("flightDone outside an active flight");

endmodule

`default_nettype wire

//--- rtl/dogSequencer.sv
`default_nettype none

module dogSequencer
    import huntScenePkg::*;
(
    input  wire        ANIM_Clk,
    input  wire        Reset,
    input  wire        Run,
    input  wire        flightDone,
    output logic [9:0] dogX,
    output logic [9:0] dogY,
    output logic [4:0] dogFrame,
    output logic [2:0] dogPhase,
    output logic       duckLaunch
);

    logic [2:0] strideCnt;  // Strides walked so far
    logic [1:0] frameCnt;   // Walk frame in stride, sniff frame in pair
    logic [1:0] sniffCnt;
    logic [2:0] holdCnt;    // Surprise and wait ticks
    logic [4:0] jumpStep;
    logic [9:0] walkK;
    logic [9:0] walkX;

    assign walkK = {8'd0, frameCnt} + 10'd1;
    assign walkX = DogHomeX + StepDx * walkK + StrideDx * {7'd0, strideCnt};

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            dogPhase   <= DogPhaseIdle;
            strideCnt  <= '0;
            frameCnt   <= '0;
            sniffCnt   <= '0;
            holdCnt    <= '0;
            jumpStep   <= '0;
            duckLaunch <= 1'b0;
        end
        else
        begin
            duckLaunch <= 1'b0;  // One tick only
            case (dogPhase)
                DogPhaseIdle:
                begin
                    if (Run)
                    begin
                        dogPhase  <= DogPhaseWalk;
                        strideCnt <= '0;
                        frameCnt  <= '0;
                    end
                end
                DogPhaseWalk:
                begin
                    frameCnt <= frameCnt + 2'd1;  // Wraps to 0 after frame 4
                    if (frameCnt == 2'd3)
                    begin
                        strideCnt <= strideCnt + 3'd1;
                        if (strideCnt == 3'(WalkStrides - 1))
                        begin
                            dogPhase <= DogPhaseSniff;
                            sniffCnt <= '0;
                        end
                    end
                end
                DogPhaseSniff:
                begin
                    frameCnt <= {1'b0, ~frameCnt[0]};
                    if (frameCnt[0])
                    begin
                        sniffCnt <= sniffCnt + 2'd1;
                        if (sniffCnt == 2'(SniffRounds - 1))
                        begin
                            dogPhase <= DogPhaseSurprised;
                            holdCnt  <= '0;
                        end
                    end
                end
                DogPhaseSurprised:
                begin
                    holdCnt <= holdCnt + 3'd1;
                    if (holdCnt == 3'(SurpriseTicks - 1))
                    begin
                        dogPhase <= DogPhaseJump;
                        jumpStep <= '0;
                    end
                end
                DogPhaseJump:
                begin
                    if (jumpStep == 5'(2 * JumpSteps - 1))
                    begin
                        dogPhase <= DogPhaseWait;  // Step stays on the landing entry
                        holdCnt  <= '0;
                    end
                    else
                        jumpStep <= jumpStep + 5'd1;
                end
                DogPhaseWait:
                begin
                    holdCnt <= holdCnt + 3'd1;
                    if (holdCnt == 3'(WaitTicks - 1))
                    begin
                        dogPhase   <= DogPhaseHidden;
                        duckLaunch <= 1'b1;  // High in first hidden tick
                    end
                end
                DogPhaseHidden:
                begin
                    if (flightDone)
                        dogPhase <= DogPhaseIdle;
                end
                default: dogPhase <= DogPhaseIdle;
            endcase
        end
    end

    always_comb
    begin
        dogX     = DogHomeX;
        dogY     = GroundY;
        dogFrame = DogFrameIdle;
        case (dogPhase)
            DogPhaseWalk:
            begin
                dogX     = walkX;
                dogFrame = DogFrameWalk + {3'd0, frameCnt};
            end
            DogPhaseSniff:
            begin
                dogX     = DogSniffX;
                dogFrame = DogFrameSniff + {4'd0, frameCnt[0]};
            end
            DogPhaseSurprised:
            begin
                dogX     = DogSniffX;
                dogFrame = DogFrameSurprised;
            end
            DogPhaseJump:
            begin
                dogX = JumpX[jumpStep];
                dogY = JumpY[jumpStep];
                if (jumpStep < 5'(JumpSteps))
                    dogFrame = DogFrameJump;         // Rising
                else
                    dogFrame = DogFrameJump + 5'd1;  // Falling
            end
            DogPhaseWait, DogPhaseHidden:
            begin
                dogX = JumpX[jumpStep];  // Behind the grass where it landed
                dogY = JumpY[jumpStep];
            end
            default: ;
        endcase
    end

    // The duck gets exactly one launch per hunt
    launchIsPulse: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        duckLaunch |=> !duckLaunch)
        else $error("duckLaunch held for more than one tick");

endmodule

`default_nettype wire

//--- rtl/huntScenePkg.sv
`default_nettype none

package huntScenePkg;

    // Scene geometry
    localparam logic [9:0] GroundY  = 10'd290;  // Dog standing row
    localparam logic [9:0] GrassY   = 10'd280;  // Anything lower hides in the grass
    localparam logic [9:0] DogHomeX = 10'd11;

    localparam logic [9:0] StrideDx    = 10'd32;  // Per stride of four frames
    localparam logic [9:0] StepDx      = 10'd8;   // Per walk frame
    localparam int         WalkStrides = 5;
    localparam int         SniffRounds = 3;       // Pairs of sniff frames

    // Stride counter has already moved past the last stride when sniffing starts
    localparam logic [9:0] DogSniffX = 10'(DogHomeX + StepDx * 4 + StrideDx * WalkStrides);

    localparam int SurpriseTicks = 2;
    localparam int JumpSteps     = 10;  // Each half of the jump
    localparam int WaitTicks     = 7;

    // Jump path, rise then fall, ends behind the grass
    localparam logic [9:0] JumpX [20] = '{
        10'd267, 10'd276, 10'd285, 10'd294, 10'd303,
        10'd312, 10'd321, 10'd330, 10'd341, 10'd352,
        10'd363, 10'd374, 10'd383, 10'd392, 10'd401,
        10'd410, 10'd419, 10'd428, 10'd437, 10'd437
    };
    localparam logic [9:0] JumpY [20] = '{
        10'd290, 10'd274, 10'd260, 10'd248, 10'd238,
        10'd229, 10'd222, 10'd217, 10'd213, 10'd212,
        10'd213, 10'd217, 10'd222, 10'd229, 10'd238,
        10'd248, 10'd260, 10'd274, 10'd290, 10'd300
    };

    // Duck flight, directions NW, W, NE, E
    localparam logic [9:0]        DuckStartY  = 10'd300;
    localparam int                FlightTicks = 24;
    localparam logic signed [7:0] DuckDx [4]  = '{-8'sd4, -8'sd6, 8'sd4, 8'sd6};
    localparam logic signed [7:0] DuckDy [4]  = '{-8'sd4, -8'sd2, -8'sd4, -8'sd2};

    // Sprite frame numbers
    localparam logic [5:0] DuckColorBase [3] = '{6'd0, 6'd20, 6'd40};  // Black, red, pink
    localparam logic [5:0] DuckDirBase   [4] = '{6'd11, 6'd15, 6'd0, 6'd4};
    localparam int         DuckWingPhases    = 3;

    localparam logic [4:0] DogFrameIdle      = 5'd0;
    localparam logic [4:0] DogFrameWalk      = 5'd1;  // Frames 1 to 4
    localparam logic [4:0] DogFrameSniff     = 5'd4;  // Frames 4 and 5
    localparam logic [4:0] DogFrameSurprised = 5'd6;
    localparam logic [4:0] DogFrameJump      = 5'd7;  // Rise 7, fall 8

    // Dog phase codes
    localparam logic [2:0] DogPhaseIdle      = 3'd0;
    localparam logic [2:0] DogPhaseWalk      = 3'd1;
    localparam logic [2:0] DogPhaseSniff     = 3'd2;
    localparam logic [2:0] DogPhaseSurprised = 3'd3;
    localparam logic [2:0] DogPhaseJump      = 3'd4;
    localparam logic [2:0] DogPhaseWait      = 3'd5;
    localparam logic [2:0] DogPhaseHidden    = 3'd6;

endpackage

`default_nettype wire
